//--- logic/ucodePkg.sv
// Microcode loader shared widths, load-file record codes and DRAM word layouts
package ucodePkg;

  ////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////

  // One decoded ASCIIized field
  localparam int LoadWordWidth = 16;
  // 80 data bits plus CALL and DISP[0:4]
  localparam int CramWidth = 86;
  // File order 64-79, 48-63, 32-47, 16-31, 0-15, then bits 80-85
  localparam int CramSlices = 6;
  // Even, odd and common words per DRAM pair
  localparam int DramTriple = 3;
  // Buffer depth, also the largest WC on one line
  localparam int MaxLineWords = 32;
  localparam int LineIdxWidth = $clog2(MaxLineWords);

  ////////////////////////////////////////
  // Record type characters
  ////////////////////////////////////////

  localparam logic [7:0] recCram = 8'h43;
  localparam logic [7:0] recDram = 8'h44;
  localparam logic [7:0] recZero = 8'h5a;
  localparam logic [7:0] recComment = 8'h3b;

  // One DRAM load word, read either as an even/odd word or as the common word
  typedef union packed {
    struct packed {
      logic [1:0] spareHi;
      logic [2:0] a;
      logic [2:0] b;
      logic [1:0] spareMid;
      logic       parity;
      logic       spareLo;
      logic       j7;
      logic [2:0] j8to10;
    } eo;
    struct packed {
      logic [11:0] spare;
      logic [3:0]  j1to4;
    } common;
  } dramWordT;

  // One DRAM location as stored
  // J5 and J6 do not exist in the hardware
  typedef struct packed {
    logic [2:0] a;
    logic [2:0] b;
    logic       parity;
    logic [3:0] j1to4;
    logic       j7;
    logic [2:0] j8to10;
  } dramEntryT;

endpackage

//--- logic/loadLineParser.sv
// Load-file line parser turning the character stream into field words and line ends
`timescale 1ns/1ps

module loadLineParser import ucodePkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     charValid,
  input  logic [7:0]               charData,
  output logic                     wordValid,
  output logic [LoadWordWidth-1:0] word,
  output logic                     lineEnd,
  output logic [7:0]               recType,
  output logic                     lineErr
);

  // Position within the current line
  localparam logic [1:0] posType = 2'd0;
  localparam logic [1:0] posSpace = 2'd1;
  localparam logic [1:0] posField = 2'd2;
  localparam logic [1:0] posEnd = 2'd3;

  localparam logic [7:0] chCr = 8'h0d;
  localparam logic [7:0] chLf = 8'h0a;
  localparam logic [7:0] chComma = 8'h2c;
  localparam logic [7:0] chSpace = 8'h20;

  logic [1:0]               pos;
  logic [LoadWordWidth-1:0] acc;
  logic                     errSeen;
  logic                     isEol;
  logic                     isFieldChar;
  logic                     knownType;

  always_comb begin
    isEol = (charData == chCr) || (charData == chLf);
    // ASCIIized range 075 through 174
    isFieldChar = (charData >= 8'o075) && (charData <= 8'o174);
    knownType = charData inside {recCram, recDram, recZero, recComment};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= posType;
      wordValid <= 1'b0;
      lineEnd <= 1'b0;
      errSeen <= 1'b0;
    end else begin
      wordValid <= 1'b0;
      lineEnd <= 1'b0;
      case (pos)
        posType: begin
          // Blank lines and the LF of a CR LF pair fall through here
          if (charValid && !isEol) begin
            recType <= charData;
            errSeen <= !knownType;
            acc <= '0;
            pos <= posSpace;
          end
        end
        posSpace: begin
          if (charValid) begin
            if (isEol) begin
              pos <= posEnd;
            end else begin
              errSeen <= errSeen | (charData != chSpace);
              pos <= posField;
            end
          end
        end
        posField: begin
          if (charValid) begin
            if (isEol || (charData == chComma)) begin
              // Empty field leaves acc at zero
              word <= acc;
              wordValid <= 1'b1;
              acc <= '0;
            end else if (isFieldChar) begin
              // Octal 100 dropped, six bits in, most significant first
              acc <= {acc[LoadWordWidth-7:0], charData[5:0]};
            end else begin
              errSeen <= 1'b1;
            end
            if (isEol) pos <= posEnd;
          end
        end
        default: begin
          // Last word went out last cycle, now close the line
          lineEnd <= 1'b1;
          lineErr <= errSeen;
          pos <= posType;
        end
      endcase
    end
  end

  // Source has to hold off for the cycle that closes a line
  assert property (@(posedge clk) disable iff (rst) (pos == posEnd) |-> !charValid);

endmodule

//--- logic/loadLineBuffer.sv
// Line buffer that checks count and checksum and commits good lines to the writer
`timescale 1ns/1ps

module loadLineBuffer import ucodePkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wordValid,
  input  logic [LoadWordWidth-1:0] word,
  input  logic                     lineEnd,
  input  logic [7:0]               recType,
  input  logic                     lineErr,
  input  logic [LineIdxWidth-1:0]  rdIndex,
  input  logic                     done,
  output logic                     commit,
  output logic                     commitType,
  output logic [LoadWordWidth-1:0] baseAddr,
  output logic [LineIdxWidth:0]    wordCount,
  output logic [LoadWordWidth-1:0] rdData,
  output logic                     lineGood,
  output logic                     lineBad
);

  // Data words plus the trailing checksum
  logic [LoadWordWidth-1:0] lineMem [MaxLineWords];

  logic [1:0]               hdrCnt;
  logic [LineIdxWidth:0]    dataCnt;
  logic [LoadWordWidth-1:0] sum;
  logic [LoadWordWidth-1:0] wcReg;
  logic [LoadWordWidth-1:0] adrReg;
  logic                     overflow;
  logic                     holding;
  logic                     takeWord;
  logic                     isC;
  logic                     isD;
  logic                     skipLine;
  logic                     wcOk;
  logic                     goodNow;

  assign takeWord = wordValid && !holding;
  assign rdData = lineMem[rdIndex];

  ////////////////////////////////////////
  // Line decision at lineEnd
  ////////////////////////////////////////

  always_comb begin
    isC = recType == recCram;
    isD = recType == recDram;
    // Z, comments and WC = 0 section ends count neither way
    skipLine = (recType == recZero) || (recType == recComment) ||
               ((isC || isD) && !lineErr && (wcReg == '0));
    // Nonzero whole number of CRAM words or DRAM triples
    wcOk = (wcReg != '0) && (wcReg <= LoadWordWidth'(MaxLineWords)) &&
           (isC ? (wcReg % LoadWordWidth'(CramSlices) == '0)
                : (wcReg % LoadWordWidth'(DramTriple) == '0));
    // Negated checksum makes the whole line sum to zero
    goodNow = (isC || isD) && !lineErr && !overflow && wcOk && (sum == '0) &&
              (LoadWordWidth'(dataCnt) == wcReg + LoadWordWidth'(1));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hdrCnt <= '0;
      dataCnt <= '0;
      sum <= '0;
      wcReg <= '0;
      overflow <= 1'b0;
      holding <= 1'b0;
      commit <= 1'b0;
      lineGood <= 1'b0;
      lineBad <= 1'b0;
    end else begin
      commit <= 1'b0;
      lineGood <= 1'b0;
      lineBad <= 1'b0;
      if (takeWord) begin
        sum <= sum + word;
        if (hdrCnt != 2'd2) hdrCnt <= hdrCnt + 2'd1;
        if (hdrCnt == 2'd0) wcReg <= word;
        if (hdrCnt == 2'd2) begin
          if (dataCnt < MaxLineWords) dataCnt <= dataCnt + 1'b1;
          else overflow <= 1'b1;
        end
      end
      if (lineEnd) begin
        commit <= goodNow;
        lineGood <= goodNow;
        lineBad <= !goodNow && !skipLine;
        holding <= goodNow;
        hdrCnt <= '0;
        dataCnt <= '0;
        sum <= '0;
        wcReg <= '0;
        overflow <= 1'b0;
      end else if (done) begin
        holding <= 1'b0;
      end
    end
  end

  // Word storage and the committed line description
  always_ff @(posedge clk) begin
    if (takeWord && (hdrCnt == 2'd1)) adrReg <= word;
    if (takeWord && (hdrCnt == 2'd2) && (dataCnt < MaxLineWords)) begin
      lineMem[dataCnt[LineIdxWidth-1:0]] <= word;
    end
    if (lineEnd) begin
      baseAddr <= adrReg;
      wordCount <= wcReg[LineIdxWidth:0];
      commitType <= isD;
    end
  end

  // No new word arrives while a committed line is still being read out
  assert property (@(posedge clk) disable iff (rst) wordValid |-> !holding);

endmodule

//--- logic/ramWriter.sv
// RAM writer that walks a committed line into CRAM words and DRAM location pairs
`timescale 1ns/1ps

module ramWriter import ucodePkg::*; #(
  parameter int CramAddrWidth = 11,
  parameter int DramAddrWidth = 9
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     commit,
  input  logic                     commitType,
  input  logic [LoadWordWidth-1:0] baseAddr,
  input  logic [LineIdxWidth:0]    wordCount,
  input  logic [LoadWordWidth-1:0] rdData,
  output logic [LineIdxWidth-1:0]  rdIndex,
  output logic                     cramWe,
  output logic [CramAddrWidth-1:0] cramWAddr,
  output logic [CramWidth-1:0]     cramWData,
  output logic                     dramWe,
  output logic [DramAddrWidth-1:0] dramWAddr,
  output dramEntryT                dramWData,
  output logic                     done
);

  // CALL and DISP[0:4] ride in the sixth word
  localparam int DataBits = CramWidth - 6;
  localparam int SpecialBits = CramWidth - DataBits;

  localparam logic [1:0] sIdle = 2'd0;
  localparam logic [1:0] sRead = 2'd1;
  localparam logic [1:0] sOdd = 2'd2;
  localparam logic [1:0] sDone = 2'd3;

  logic [1:0]               state;
  logic [LineIdxWidth:0]    idx;
  logic [LineIdxWidth:0]    cnt;
  logic [2:0]               slice;
  logic                     isDram;
  logic [LoadWordWidth-1:0] wAddr;
  logic [DataBits-1:0]      cramAsm;
  dramWordT                 curW;
  dramWordT                 evenW;
  dramWordT                 oddW;
  dramWordT                 commonW;
  logic                     lastWord;

  assign curW = rdData;
  assign rdIndex = idx[LineIdxWidth-1:0];
  assign lastWord = (idx + 1'b1) == cnt;
  assign done = state == sDone;

  // One location from its own word; J1-4 and J7 are shared by the pair
  function automatic dramEntryT buildEntry(dramWordT own, dramWordT odd, dramWordT shared);
    dramEntryT e;
    e.a = own.eo.a;
    e.b = own.eo.b;
    e.parity = own.eo.parity;
    e.j1to4 = shared.common.j1to4;
    e.j7 = odd.eo.j7;
    e.j8to10 = own.eo.j8to10;
    return e;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= sIdle;
      idx <= '0;
      slice <= '0;
      cramWe <= 1'b0;
      dramWe <= 1'b0;
    end else begin
      cramWe <= 1'b0;
      dramWe <= 1'b0;
      case (state)
        sIdle: begin
          if (commit) begin
            state <= sRead;
            idx <= '0;
            slice <= '0;
            cnt <= wordCount;
            isDram <= commitType;
            wAddr <= baseAddr;
          end
        end
        sRead: begin
          idx <= idx + 1'b1;
          slice <= slice + 3'd1;
          if (!isDram) begin
            // First slice ends up in bits 79:64
            cramAsm <= {cramAsm[DataBits-LoadWordWidth-1:0], rdData};
            if (slice == 3'(CramSlices - 1)) begin
              cramWe <= 1'b1;
              cramWAddr <= CramAddrWidth'(wAddr);
              cramWData <= {rdData[SpecialBits-1:0], cramAsm};
              wAddr <= wAddr + 1'b1;
              slice <= '0;
            end
            if (lastWord) state <= sDone;
          end else if (slice == 3'd0) begin
            evenW <= curW;
          end else if (slice == 3'd1) begin
            oddW <= curW;
          end else begin
            // Common word completes the triple, even location goes first
            commonW <= curW;
            dramWe <= 1'b1;
            dramWAddr <= DramAddrWidth'(wAddr);
            dramWData <= buildEntry(evenW, oddW, curW);
            slice <= '0;
            state <= sOdd;
          end
        end
        sOdd: begin
          dramWe <= 1'b1;
          dramWAddr <= DramAddrWidth'(wAddr + 16'd1);
          dramWData <= buildEntry(oddW, oddW, commonW);
          wAddr <= wAddr + 16'd2;
          state <= (idx == cnt) ? sDone : sRead;
        end
        default: begin
          state <= sIdle;
        end
      endcase
    end
  end

  // CRAM and DRAM traffic never share a cycle
  assert property (@(posedge clk) disable iff (rst) !(cramWe && dramWe));

endmodule

//--- logic/microStore.sv
// Microcode store holding the CRAM and DRAM arrays with registered read ports
`timescale 1ns/1ps

module microStore import ucodePkg::*; #(
  parameter int CramAddrWidth = 11,
  parameter int DramAddrWidth = 9
) (
  input  logic                     clk,
  input  logic                     cramWe,
  input  logic [CramAddrWidth-1:0] cramWAddr,
  input  logic [CramWidth-1:0]     cramWData,
  input  logic [CramAddrWidth-1:0] cramRdAddr,
  input  logic                     dramWe,
  input  logic [DramAddrWidth-1:0] dramWAddr,
  input  dramEntryT                dramWData,
  input  logic [DramAddrWidth-1:0] dramRdAddr,
  output logic [CramWidth-1:0]     cramRdData,
  output dramEntryT                dramRdData
);

  ////////////////////////////////////////
  // Arrays
  ////////////////////////////////////////

  logic [CramWidth-1:0] cram [2**CramAddrWidth];
  // Even and odd locations of a pair sit side by side
  dramEntryT            dram [2**DramAddrWidth];

  // Control RAM, one cycle read
  always_ff @(posedge clk) begin
    if (cramWe) cram[cramWAddr] <= cramWData;
    cramRdData <= cram[cramRdAddr];
  end

  // Dispatch RAM, one cycle read
  always_ff @(posedge clk) begin
    if (dramWe) dram[dramWAddr] <= dramWData;
    dramRdData <= dram[dramRdAddr];
  end

endmodule

//--- logic/loaderStatus.sv
// Loader status with line and write counters and the busy level toward the source
`timescale 1ns/1ps

module loaderStatus (
  input  logic        clk,
  input  logic        rst,
  input  logic        lineEnd,
  input  logic        lineGood,
  input  logic        lineBad,
  input  logic        cramWe,
  input  logic        dramWe,
  input  logic        done,
  output logic        busy,
  output logic [15:0] goodLines,
  output logic [15:0] badLines,
  output logic [15:0] cramWrites,
  output logic [15:0] dramWrites
);

  // Buffer decision lands the cycle after lineEnd
  logic decidePending;

  always_ff @(posedge clk) begin
    if (rst) begin
      decidePending <= 1'b0;
      busy <= 1'b0;
      goodLines <= '0;
      badLines <= '0;
      cramWrites <= '0;
      dramWrites <= '0;
    end else begin
      decidePending <= lineEnd;
      // Bad or skipped lines release at once, good ones wait for the writer
      if (lineEnd) busy <= 1'b1;
      else if ((decidePending && !lineGood) || done) busy <= 1'b0;
      if (lineGood) goodLines <= goodLines + 16'd1;
      if (lineBad) badLines <= badLines + 16'd1;
      if (cramWe) cramWrites <= cramWrites + 16'd1;
      // One per location, so a pair counts twice
      if (dramWe) dramWrites <= dramWrites + 16'd1;
    end
  end

endmodule

//--- logic/ucodeLoader.sv
// KL10 microcode loader top level from load-file characters to CRAM and DRAM
`timescale 1ns/1ps

module ucodeLoader import ucodePkg::*; #(
  parameter int CramAddrWidth = 11,
  parameter int DramAddrWidth = 9
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     charValid,
  input  logic [7:0]               charData,
  output logic                     busy,
  input  logic [CramAddrWidth-1:0] cramRdAddr,
  output logic [CramWidth-1:0]     cramRdData,
  input  logic [DramAddrWidth-1:0] dramRdAddr,
  output dramEntryT                dramRdData,
  output logic [15:0]              goodLines,
  output logic [15:0]              badLines,
  output logic [15:0]              cramWrites,
  output logic [15:0]              dramWrites
);

  ////////////////////////////////////////
  // Parser to buffer
  ////////////////////////////////////////

  logic                     wordValid;
  logic [LoadWordWidth-1:0] word;
  logic                     lineEnd;
  logic [7:0]               recType;
  logic                     lineErr;

  // Buffer to writer
  logic                     commit;
  logic                     commitType;
  logic [LoadWordWidth-1:0] baseAddr;
  logic [LineIdxWidth:0]    wordCount;
  logic [LineIdxWidth-1:0]  rdIndex;
  logic [LoadWordWidth-1:0] rdData;
  logic                     lineGood;
  logic                     lineBad;
  logic                     done;

  // Writer to store
  logic                     cramWe;
  logic [CramAddrWidth-1:0] cramWAddr;
  logic [CramWidth-1:0]     cramWData;
  logic                     dramWe;
  logic [DramAddrWidth-1:0] dramWAddr;
  dramEntryT                dramWData;

  loadLineParser loadLineParser_i (
    .clk(clk),
    .rst(rst),
    .charValid(charValid),
    .charData(charData),
    .wordValid(wordValid),
    .word(word),
    .lineEnd(lineEnd),
    .recType(recType),
    .lineErr(lineErr)
  );

  loadLineBuffer loadLineBuffer_i (
    .clk(clk),
    .rst(rst),
    .wordValid(wordValid),
    .word(word),
    .lineEnd(lineEnd),
    .recType(recType),
    .lineErr(lineErr),
    .rdIndex(rdIndex),
    .done(done),
    .commit(commit),
    .commitType(commitType),
    .baseAddr(baseAddr),
    .wordCount(wordCount),
    .rdData(rdData),
    .lineGood(lineGood),
    .lineBad(lineBad)
  );

  ramWriter #(
    .CramAddrWidth(CramAddrWidth),
    .DramAddrWidth(DramAddrWidth)
  ) ramWriter_i (
    .clk(clk),
    .rst(rst),
    .commit(commit),
    .commitType(commitType),
    .baseAddr(baseAddr),
    .wordCount(wordCount),
    .rdData(rdData),
    .rdIndex(rdIndex),
    .cramWe(cramWe),
    .cramWAddr(cramWAddr),
    .cramWData(cramWData),
    .dramWe(dramWe),
    .dramWAddr(dramWAddr),
    .dramWData(dramWData),
    .done(done)
  );

  microStore #(
    .CramAddrWidth(CramAddrWidth),
    .DramAddrWidth(DramAddrWidth)
  ) microStore_i (
    .clk(clk),
    .cramWe(cramWe),
    .cramWAddr(cramWAddr),
    .cramWData(cramWData),
    .cramRdAddr(cramRdAddr),
    .dramWe(dramWe),
    .dramWAddr(dramWAddr),
    .dramWData(dramWData),
    .dramRdAddr(dramRdAddr),
    .cramRdData(cramRdData),
    .dramRdData(dramRdData)
  );

  loaderStatus loaderStatus_i (
    .clk(clk),
    .rst(rst),
    .lineEnd(lineEnd),
    .lineGood(lineGood),
    .lineBad(lineBad),
    .cramWe(cramWe),
    .dramWe(dramWe),
    .done(done),
    .busy(busy),
    .goodLines(goodLines),
    .badLines(badLines),
    .cramWrites(cramWrites),
    .dramWrites(dramWrites)
  );

endmodule

//--- tests/ucodeLoaderTb.sv
// Testbench for the microcode loader fed with load lines and expected contents from a data file
`timescale 1ns/1ps

module ucodeLoaderTb import ucodePkg::*; ();

  localparam int CramAddrWidth = 11;
  localparam int DramAddrWidth = 9;

  logic                     clk;
  logic                     rst;
  logic                     charValid;
  logic [7:0]               charData;
  logic                     busy;
  logic [CramAddrWidth-1:0] cramRdAddr;
  logic [CramWidth-1:0]     cramRdData;
  logic [DramAddrWidth-1:0] dramRdAddr;
  dramEntryT                dramRdData;
  logic [15:0]              goodLines;
  logic [15:0]              badLines;
  logic [15:0]              cramWrites;
  logic [15:0]              dramWrites;

  // Commands from the data file in file order
  string cmds[$];
  int    errorCount;
  int    checksRun;
  int    charTotal;
  int    cycleCount;
  int    cycleLimit;

  ucodeLoader #(
    .CramAddrWidth(CramAddrWidth),
    .DramAddrWidth(DramAddrWidth)
  ) ucodeLoader_i (
    .clk(clk),
    .rst(rst),
    .charValid(charValid),
    .charData(charData),
    .busy(busy),
    .cramRdAddr(cramRdAddr),
    .cramRdData(cramRdData),
    .dramRdAddr(dramRdAddr),
    .dramRdData(dramRdData),
    .goodLines(goodLines),
    .badLines(badLines),
    .cramWrites(cramWrites),
    .dramWrites(dramWrites)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Watchdog whose limit is known once the data file is read
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if ((cycleLimit != 0) && (cycleCount >= cycleLimit)) begin
      $display("Timeout after %0d cycles, the loader never went idle", cycleLimit);
      $display("Checks: %0d, errors: %0d", checksRun, errorCount);
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic checkCram(input logic [CramAddrWidth-1:0] addr,
                           input logic [CramWidth-1:0] got,
                           input logic [CramWidth-1:0] exp);
    checksRun++;
    if (got !== exp) begin
      errorCount++;
      $display("ERROR cramRdData at %h: got %h, expected %h", addr, got, exp);
    end
  endtask

  task automatic checkDram(input logic [DramAddrWidth-1:0] addr,
                           input dramEntryT got,
                           input dramEntryT exp);
    checksRun++;
    if (got !== exp) begin
      errorCount++;
      $display("ERROR dramRdData at %h: got %h, expected %h", addr, got, exp);
    end
  endtask

  task automatic checkCount(input string name, input logic [15:0] got, input logic [15:0] exp);
    checksRun++;
    if (got !== exp) begin
      errorCount++;
      $display("ERROR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Data file
  ////////////////////////////////////////

  // Drop the line terminator that fgets keeps
  function automatic string stripEol(input string s);
    string t;
    t = s;
    while ((t.len() > 0) &&
           ((t.getc(t.len() - 1) == 8'h0a) || (t.getc(t.len() - 1) == 8'h0d))) begin
      t = t.substr(0, t.len() - 2);
    end
    return t;
  endfunction

  task automatic loadCommands();
    int    fd;
    string line;
    fd = $fopen("tests/loaderTests.dat", "r");
    if (fd == 0) begin
      $display("Cannot open tests/loaderTests.dat for reading");
      errorCount++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          line = stripEol(line);
          // Blank lines and # notes carry no command
          if ((line.len() > 0) && (line.getc(0) != "#")) begin
            cmds.push_back(line);
            // Text after the tag plus the LF sent at its end
            if (line.getc(0) == "L") charTotal += line.len() - 1;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Busy rises two cycles after the line end and falls once the line is handled
  task automatic waitIdle();
    @(negedge clk);
    while (!busy) @(negedge clk);
    while (busy) @(negedge clk);
  endtask

  // One character per cycle starting after the L tag
  task automatic sendLine(input string text);
    int i;
    for (i = 2; i < text.len(); i++) begin
      @(posedge clk);
      charValid <= 1'b1;
      charData <= text.getc(i);
    end
    @(posedge clk);
    charValid <= 1'b1;
    charData <= 8'h0a;
    @(posedge clk);
    charValid <= 1'b0;
    waitIdle();
  endtask

  // Registered read port gives data one cycle after the address
  task automatic verifyCramWord(input logic [CramAddrWidth-1:0] addr,
                                input logic [CramWidth-1:0] exp);
    @(posedge clk);
    cramRdAddr <= addr;
    @(posedge clk);
    @(negedge clk);
    checkCram(addr, cramRdData, exp);
  endtask

  task automatic verifyDramEntry(input logic [DramAddrWidth-1:0] addr, input dramEntryT exp);
    @(posedge clk);
    dramRdAddr <= addr;
    @(posedge clk);
    @(negedge clk);
    checkDram(addr, dramRdData, exp);
  endtask

  task automatic runCommand(input string cmd);
    string       rest;
    logic [31:0] addr;
    logic [87:0] value;
    logic [15:0] expGood;
    logic [15:0] expBad;
    logic [15:0] expCram;
    logic [15:0] expDram;
    int          n;
    case (cmd.getc(0))
      "L": sendLine(cmd);
      "R": begin
        n = 0;
        if (cmd.len() > 4) begin
          rest = cmd.substr(4, cmd.len() - 1);
          n = $sscanf(rest, "%h %h", addr, value);
        end
        if (n != 2) begin
          errorCount++;
          $display("Read line has no address and value: %s", cmd);
        end else if (cmd.getc(2) == "C") begin
          verifyCramWord(addr[CramAddrWidth-1:0], value[CramWidth-1:0]);
        end else if (cmd.getc(2) == "D") begin
          verifyDramEntry(addr[DramAddrWidth-1:0], value[$bits(dramEntryT)-1:0]);
        end else begin
          errorCount++;
          $display("Read line names neither CRAM nor DRAM: %s", cmd);
        end
      end
      "S": begin
        n = $sscanf(cmd, "S %h %h %h %h", expGood, expBad, expCram, expDram);
        if (n != 4) begin
          errorCount++;
          $display("Status line does not hold four counter values: %s", cmd);
        end else begin
          @(negedge clk);
          checkCount("goodLines", goodLines, expGood);
          checkCount("badLines", badLines, expBad);
          checkCount("cramWrites", cramWrites, expCram);
          checkCount("dramWrites", dramWrites, expDram);
        end
      end
      default: begin
        errorCount++;
        $display("Unknown command in the data file: %s", cmd);
      end
    endcase
  endtask

  initial begin
    rst = 1'b1;
    charValid = 1'b0;
    charData = 8'h00;
    cramRdAddr = '0;
    dramRdAddr = '0;
    errorCount = 0;
    checksRun = 0;
    charTotal = 0;
    cycleCount = 0;
    cycleLimit = 0;
    loadCommands();
    cycleLimit = charTotal * 4 + 200;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    foreach (cmds[i]) runCommand(cmds[i]);
    repeat (2) @(posedge clk);
    if (checksRun == 0) begin
      errorCount++;
      $display("No checks were run");
    end
    $display("Checks: %0d, errors: %0d", checksRun, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- tests/loaderTests.dat
# L <load-file line> | R C|D <addr hex> <expected word hex> | S <good> <bad> <cram> <dram>
# Addresses, words and counters in hex, commands run top to bottom
# Two CRAM words at 010 and 011
L C L,P,ABC,DEF,GHI,JKL,MNO,z,STU,VWX,YZa,bcd,efg,A,AEc
R C 010 3A108341467209A2CCD38F
R C 011 01351565D896A128E459A7
# One DRAM pair at 022, J1-4 from the common word, J7 from the odd word
L D C,b,Bhc,AxM,CJ,K[a
R D 022 55AB
R D 023 3CAD
# Wrong checksum over 010 leaves the old word
L C F,P,PPP,PPP,PPP,PPP,PPP,A,AAA
R C 010 3A108341467209A2CCD38F
S 2 1 2 2
# Characters 075 to 077 and empty fields
L C F,R,?=>,,??,=,,>,N?p
R C 012 3EFF7E00000FFF003D0000
S 3 1 3 2
# Section end, Z record and comment change nothing
L C @,P,@
L Z C,P,A,B,C
L ; KL10 CRAM and DRAM test load
R C 010 3A108341467209A2CCD38F
S 3 1 3 2
# WC of 5 on a C line with a good checksum
L C E,Q,A,A,A,A,A,O?e
R C 011 01351565D896A128E459A7
S 3 2 3 2

//--- project.f
logic/ucodePkg.sv
logic/loadLineParser.sv
logic/loadLineBuffer.sv
logic/ramWriter.sv
logic/microStore.sv
logic/loaderStatus.sv
logic/ucodeLoader.sv
tests/ucodeLoaderTb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps --top-module ucodeLoaderTb \
  -f project.f -o simv \
  && ./obj_dir/simv | tee /dev/stderr | grep -q 'All tests passed!' \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
